//--- source/rv_isa_pkg.sv
package rv_isa_pkg;

  // base integer width
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [31:0]     insn_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [6:0]      opcode_t;

  // major opcodes, the low two bits are always 11
  localparam opcode_t OP_LUI     = 7'b01_101_11;
  localparam opcode_t OP_AUIPC   = 7'b00_101_11;
  localparam opcode_t OP_BRANCH  = 7'b11_000_11;
  localparam opcode_t OP_REG_IMM = 7'b00_100_11;
  localparam opcode_t OP_REG_REG = 7'b01_100_11;
  localparam opcode_t OP_ENVIRON = 7'b11_100_11;

  // funct3 for arithmetic, shared by the reg-imm and reg-reg forms
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct3 for conditional branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // funct7, alt selects sub and the arithmetic right shift
  localparam logic [6:0] F7_BASE = 7'd0;
  localparam logic [6:0] F7_ALT  = 7'd32;

  // pc step for uncompressed instructions
  localparam word_t INSN_BYTES = 32'd4;

endpackage

//--- source/core_ctrl_pkg.sv
package core_ctrl_pkg;

  // operation selected by decode for the ALU
  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND,
    PASS_B
  } alu_op_e;

  // branch condition, NONE for every non-branch instruction
  typedef enum logic [2:0] {
    NONE,
    EQ,
    NE,
    LT,
    GE,
    LTU,
    GEU
  } branch_e;

endpackage

//--- source/fetch_decode.sv
module fetch_decode #(
  parameter rv_isa_pkg::word_t RESET_PC = '0
) (
  input  logic                   clk,
  input  logic                   rst,
  input  rv_isa_pkg::insn_t      i_insn,
  input  logic                   i_branch_taken,
  input  rv_isa_pkg::word_t      i_branch_target,
  output rv_isa_pkg::word_t      o_pc,
  output rv_isa_pkg::reg_addr_t  o_rs1,
  output rv_isa_pkg::reg_addr_t  o_rs2,
  output rv_isa_pkg::reg_addr_t  o_rd,
  output rv_isa_pkg::word_t      o_imm,
  output logic                   o_use_imm,
  output logic                   o_a_is_pc,
  output core_ctrl_pkg::alu_op_e o_alu_op,
  output core_ctrl_pkg::branch_e o_branch,
  output logic                   o_wr_en,
  output logic                   o_halt
);
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_b;
  word_t      imm_u;
  logic       f7_checked;
  logic       alt_ok;
  logic       arith_ok;
  logic       wr_en;
  logic       halt;

  assign opcode = i_insn[6:0];
  assign funct3 = i_insn[14:12];
  assign funct7 = i_insn[31:25];
  assign o_rd   = i_insn[11:7];
  assign o_rs1  = i_insn[19:15];
  assign o_rs2  = i_insn[24:20];

  assign imm_i = {{20{i_insn[31]}}, i_insn[31:20]};
  // B format scatters the offset, bit 0 is implied zero
  assign imm_b = {{19{i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
  assign imm_u = {i_insn[31:12], 12'b0};

  // funct7 only means something for shifts and reg-reg ops
  assign f7_checked = (opcode == OP_REG_REG) || (funct3 == F3_SLL) || (funct3 == F3_SR);
  assign alt_ok     = (funct3 == F3_SR) || ((opcode == OP_REG_REG) && (funct3 == F3_ADD));
  assign arith_ok   = !f7_checked || (funct7 == F7_BASE) || ((funct7 == F7_ALT) && alt_ok);

  always_comb
  begin
    o_alu_op  = ADD;
    o_branch  = NONE;
    o_use_imm = 1'b0;
    o_a_is_pc = 1'b0;
    o_imm     = imm_i;
    wr_en     = 1'b0;
    halt      = 1'b0;
    case (opcode)
      OP_LUI:
      begin
        o_alu_op  = PASS_B;
        o_use_imm = 1'b1;
        o_imm     = imm_u;
        wr_en     = 1'b1;
      end
      OP_AUIPC:
      begin
        o_a_is_pc = 1'b1;
        o_use_imm = 1'b1;
        o_imm     = imm_u;
        wr_en     = 1'b1;
      end
      OP_REG_IMM, OP_REG_REG:
      begin
        o_use_imm = (opcode == OP_REG_IMM);
        wr_en     = arith_ok;
        case (funct3)
          F3_ADD:  o_alu_op = ((opcode == OP_REG_REG) && (funct7 == F7_ALT)) ? SUB : ADD;
          F3_SLL:  o_alu_op = SLL;
          F3_SLT:  o_alu_op = SLT;
          F3_SLTU: o_alu_op = SLTU;
          F3_XOR:  o_alu_op = XOR;
          F3_SR:   o_alu_op = (funct7 == F7_ALT) ? SRA : SRL;
          F3_OR:   o_alu_op = OR;
          default: o_alu_op = AND;
        endcase
      end
      OP_BRANCH:
      begin
        o_imm = imm_b;
        case (funct3)
          F3_BEQ:  o_branch = EQ;
          F3_BNE:  o_branch = NE;
          F3_BLT:  o_branch = LT;
          F3_BGE:  o_branch = GE;
          F3_BLTU: o_branch = LTU;
          F3_BGEU: o_branch = GEU;
          default: o_branch = NONE;
        endcase
      end
      // only the plain ecall encoding halts
      OP_ENVIRON: halt = (i_insn[31:7] == '0);
      default:    halt = 1'b0;
    endcase
  end

  // nothing retires while the core sits in reset
  assign o_wr_en = wr_en && !rst;
  assign o_halt  = halt && !rst;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      o_pc <= RESET_PC;
    end
    else if (i_branch_taken)
    begin
      o_pc <= i_branch_target;
    end
    else if (!halt)
    begin
      o_pc <= o_pc + INSN_BYTES;
    end
  end

  // targets arrive from execute, so alignment depends on both stages
  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) o_pc[1:0] == 2'b00);

endmodule

//--- source/reg_file.sv
module reg_file #(
  parameter int NUM_REGS = 32
) (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_isa_pkg::reg_addr_t i_rs1,
  input  rv_isa_pkg::reg_addr_t i_rs2,
  input  rv_isa_pkg::reg_addr_t i_rd,
  input  logic                  i_wr_en,
  input  rv_isa_pkg::word_t     i_wr_data,
  output rv_isa_pkg::word_t     o_rs1_data,
  output rv_isa_pkg::word_t     o_rs2_data
);
  import rv_isa_pkg::*;

  // x0 has no storage
  word_t regs [1:NUM_REGS-1];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 1; i < NUM_REGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (i_wr_en && (i_rd != '0) && (int'(i_rd) < NUM_REGS))
    begin
      regs[i_rd] <= i_wr_data;
    end
  end

  // x0 and indices past the last register read as zero
  assign o_rs1_data = ((i_rs1 == '0) || (int'(i_rs1) >= NUM_REGS)) ? '0 : regs[i_rs1];
  assign o_rs2_data = ((i_rs2 == '0) || (int'(i_rs2) >= NUM_REGS)) ? '0 : regs[i_rs2];

  // decode must not hand an RV32E core a register it lacks
  a_rd_in_range: assert property (@(posedge clk) disable iff (rst)
    i_wr_en |-> (int'(i_rd) < NUM_REGS));

endmodule

//--- source/execute.sv
module execute (
  input  rv_isa_pkg::word_t      i_pc,
  input  rv_isa_pkg::word_t      i_rs1_data,
  input  rv_isa_pkg::word_t      i_rs2_data,
  input  rv_isa_pkg::word_t      i_imm,
  input  logic                   i_use_imm,
  input  logic                   i_a_is_pc,
  input  core_ctrl_pkg::alu_op_e i_alu_op,
  input  core_ctrl_pkg::branch_e i_branch,
  input  logic                   i_wr_en,
  input  rv_isa_pkg::reg_addr_t  i_rd,
  output logic                   o_wb_en,
  output rv_isa_pkg::reg_addr_t  o_wb_rd,
  output rv_isa_pkg::word_t      o_wb_data,
  output logic                   o_branch_taken,
  output rv_isa_pkg::word_t      o_branch_target
);
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;

  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;
  logic       a_lt_b;
  logic       a_ltu_b;
  logic       rs_eq;
  logic       rs_lt;
  logic       rs_ltu;

  // auipc is the only user of the pc as operand a
  assign op_a  = i_a_is_pc ? i_pc : i_rs1_data;
  assign op_b  = i_use_imm ? i_imm : i_rs2_data;
  assign shamt = op_b[4:0];

  assign a_lt_b  = $signed(op_a) < $signed(op_b);
  assign a_ltu_b = op_a < op_b;

  always_comb
  begin
    case (i_alu_op)
      ADD:     o_wb_data = op_a + op_b;
      SUB:     o_wb_data = op_a - op_b;
      SLL:     o_wb_data = op_a << shamt;
      SLT:     o_wb_data = {{(XLEN-1){1'b0}}, a_lt_b};
      SLTU:    o_wb_data = {{(XLEN-1){1'b0}}, a_ltu_b};
      XOR:     o_wb_data = op_a ^ op_b;
      SRL:     o_wb_data = op_a >> shamt;
      // sign fill comes from the signed cast
      SRA:     o_wb_data = $signed(op_a) >>> shamt;
      OR:      o_wb_data = op_a | op_b;
      AND:     o_wb_data = op_a & op_b;
      PASS_B:  o_wb_data = op_b;
      default: o_wb_data = '0;
    endcase
  end

  // branches always compare the two registers, never the immediate
  assign rs_eq  = i_rs1_data == i_rs2_data;
  assign rs_lt  = $signed(i_rs1_data) < $signed(i_rs2_data);
  assign rs_ltu = i_rs1_data < i_rs2_data;

  always_comb
  begin
    case (i_branch)
      EQ:      o_branch_taken = rs_eq;
      NE:      o_branch_taken = !rs_eq;
      LT:      o_branch_taken = rs_lt;
      GE:      o_branch_taken = !rs_lt;
      LTU:     o_branch_taken = rs_ltu;
      GEU:     o_branch_taken = !rs_ltu;
      default: o_branch_taken = 1'b0;
    endcase
  end

  assign o_branch_target = i_pc + i_imm;

  assign o_wb_en = i_wr_en;
  assign o_wb_rd = i_rd;

  // decode and execute together keep branches from writing back
  always_comb
  begin
    a_no_wb_on_branch: assert final (!(o_branch_taken && o_wb_en))
      else $error("write-back enabled on a taken branch");
  end

endmodule

//--- source/rv_core.sv
module rv_core #(
  parameter rv_isa_pkg::word_t RESET_PC = '0,
  parameter int                NUM_REGS = 32
) (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_isa_pkg::insn_t     i_insn,
  output rv_isa_pkg::word_t     o_pc,
  output logic                  o_halt,
  output logic                  o_wb_en,
  output rv_isa_pkg::reg_addr_t o_wb_rd,
  output rv_isa_pkg::word_t     o_wb_data
);
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;

  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  word_t     imm;
  logic      use_imm;
  logic      a_is_pc;
  alu_op_e   alu_op;
  branch_e   branch;
  logic      wr_en;
  word_t     rs1_data;
  word_t     rs2_data;
  logic      branch_taken;
  word_t     branch_target;

  fetch_decode #(
    .RESET_PC (RESET_PC)
  ) fetch_decode_inst (
    .clk             (clk),
    .rst             (rst),
    .i_insn          (i_insn),
    .i_branch_taken  (branch_taken),
    .i_branch_target (branch_target),
    .o_pc            (o_pc),
    .o_rs1           (rs1),
    .o_rs2           (rs2),
    .o_rd            (rd),
    .o_imm           (imm),
    .o_use_imm       (use_imm),
    .o_a_is_pc       (a_is_pc),
    .o_alu_op        (alu_op),
    .o_branch        (branch),
    .o_wr_en         (wr_en),
    .o_halt          (o_halt)
  );

  reg_file #(
    .NUM_REGS (NUM_REGS)
  ) reg_file_inst (
    .clk        (clk),
    .rst        (rst),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .i_rd       (o_wb_rd),
    .i_wr_en    (o_wb_en),
    .i_wr_data  (o_wb_data),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  // write-back goes to the register file and out as the retire trace
  execute execute_inst (
    .i_pc            (o_pc),
    .i_rs1_data      (rs1_data),
    .i_rs2_data      (rs2_data),
    .i_imm           (imm),
    .i_use_imm       (use_imm),
    .i_a_is_pc       (a_is_pc),
    .i_alu_op        (alu_op),
    .i_branch        (branch),
    .i_wr_en         (wr_en),
    .i_rd            (rd),
    .o_wb_en         (o_wb_en),
    .o_wb_rd         (o_wb_rd),
    .o_wb_data       (o_wb_data),
    .o_branch_taken  (branch_taken),
    .o_branch_target (branch_target)
  );

endmodule

//--- bench/rv_core_prog.svh
`ifndef RV_CORE_PROG_SVH
`define RV_CORE_PROG_SVH

// columns: name, instruction, expected pc, write enable, rd, write data, halt
// rd and data are only compared on rows that expect a write
task automatic load_program();
  // x1 = 100, x2 = -5, then the rest of the register-immediate group
  add_row("addi",       enc_i(F3_ADD, 1, 0, 12'd100),    32'h00, 1, 1, 32'h0000_0064, 0);
  add_row("addi neg",   enc_i(F3_ADD, 2, 0, 12'hffb),    32'h04, 1, 2, 32'hffff_fffb, 0);
  add_row("slti",       enc_i(F3_SLT, 3, 2, 12'd1),      32'h08, 1, 3, 32'h0000_0001, 0);
  add_row("sltiu",      enc_i(F3_SLTU, 4, 2, 12'd1),     32'h0c, 1, 4, 32'h0000_0000, 0);
  add_row("xori",       enc_i(F3_XOR, 5, 1, 12'hfff),    32'h10, 1, 5, 32'hffff_ff9b, 0);
  add_row("ori",        enc_i(F3_OR, 6, 1, 12'h0f0),     32'h14, 1, 6, 32'h0000_00f4, 0);
  add_row("andi",       enc_i(F3_AND, 7, 1, 12'h0f0),    32'h18, 1, 7, 32'h0000_0060, 0);
  add_row("slli",       enc_i(F3_SLL, 8, 1, 12'h004),    32'h1c, 1, 8, 32'h0000_0640, 0);
  add_row("srli",       enc_i(F3_SR, 9, 2, 12'h004),     32'h20, 1, 9, 32'h0fff_ffff, 0);
  add_row("srai",       enc_i(F3_SR, 10, 2, 12'h401),    32'h24, 1, 10, 32'hffff_fffd, 0);
  add_row("addi x0",    enc_i(F3_ADD, 0, 1, 12'd7),      32'h28, 1, 0, 32'h0000_006b, 0);
  add_row("read x0",    enc_r(F7_BASE, F3_ADD, 11, 0, 1),  32'h2c, 1, 11, 32'h0000_0064, 0);
  // register-register group on the values above
  add_row("add",        enc_r(F7_BASE, F3_ADD, 12, 1, 2),  32'h30, 1, 12, 32'h0000_005f, 0);
  add_row("sub",        enc_r(F7_ALT, F3_ADD, 13, 0, 1),   32'h34, 1, 13, 32'hffff_ff9c, 0);
  add_row("sll",        enc_r(F7_BASE, F3_SLL, 14, 1, 10), 32'h38, 1, 14, 32'h8000_0000, 0);
  add_row("slt",        enc_r(F7_BASE, F3_SLT, 15, 2, 1),  32'h3c, 1, 15, 32'h0000_0001, 0);
  add_row("sltu",       enc_r(F7_BASE, F3_SLTU, 16, 2, 1), 32'h40, 1, 16, 32'h0000_0000, 0);
  add_row("xor",        enc_r(F7_BASE, F3_XOR, 17, 1, 2),  32'h44, 1, 17, 32'hffff_ff9f, 0);
  add_row("or",         enc_r(F7_BASE, F3_OR, 18, 6, 7),   32'h48, 1, 18, 32'h0000_00f4, 0);
  add_row("and",        enc_r(F7_BASE, F3_AND, 19, 1, 2),  32'h4c, 1, 19, 32'h0000_0060, 0);
  add_row("srl",        enc_r(F7_BASE, F3_SR, 20, 2, 3),   32'h50, 1, 20, 32'h7fff_fffd, 0);
  add_row("sra",        enc_r(F7_ALT, F3_SR, 21, 2, 3),    32'h54, 1, 21, 32'hffff_fffd, 0);
  add_row("lui",        enc_u(OP_LUI, 22, 20'h12345),    32'h58, 1, 22, 32'h1234_5000, 0);
  add_row("auipc",      enc_u(OP_AUIPC, 23, 20'h00001),  32'h5c, 1, 23, 32'h0000_105c, 0);
  add_row("auipc neg",  enc_u(OP_AUIPC, 24, 20'hfffff),  32'h60, 1, 24, 32'hffff_f060, 0);
  // taken branches skip one word, x11 equals x1
  add_row("beq taken",  enc_b(F3_BEQ, 1, 11, 13'd8),     32'h64, 0, 0, 32'h0, 0);
  add_row("beq not",    enc_b(F3_BEQ, 1, 2, 13'd8),      32'h6c, 0, 0, 32'h0, 0);
  add_row("bne taken",  enc_b(F3_BNE, 1, 2, 13'd8),      32'h70, 0, 0, 32'h0, 0);
  add_row("bne not",    enc_b(F3_BNE, 1, 11, 13'd8),     32'h78, 0, 0, 32'h0, 0);
  add_row("blt taken",  enc_b(F3_BLT, 2, 1, 13'd8),      32'h7c, 0, 0, 32'h0, 0);
  add_row("blt not",    enc_b(F3_BLT, 1, 2, 13'd8),      32'h84, 0, 0, 32'h0, 0);
  add_row("bge taken",  enc_b(F3_BGE, 1, 2, 13'd8),      32'h88, 0, 0, 32'h0, 0);
  add_row("bge not",    enc_b(F3_BGE, 2, 1, 13'd8),      32'h90, 0, 0, 32'h0, 0);
  add_row("bltu taken", enc_b(F3_BLTU, 1, 2, 13'd8),     32'h94, 0, 0, 32'h0, 0);
  add_row("bltu not",   enc_b(F3_BLTU, 2, 1, 13'd8),     32'h9c, 0, 0, 32'h0, 0);
  add_row("bgeu taken", enc_b(F3_BGEU, 2, 1, 13'd8),     32'ha0, 0, 0, 32'h0, 0);
  add_row("bgeu not",   enc_b(F3_BGEU, 1, 2, 13'd8),     32'ha8, 0, 0, 32'h0, 0);
  // pc stays on the ecall
  add_row("ecall",      ECALL,                           32'hac, 0, 0, 32'h0, 1);
  add_row("ecall hold", ECALL,                           32'hac, 0, 0, 32'h0, 1);
  add_row("ecall hold", ECALL,                           32'hac, 0, 0, 32'h0, 1);
endtask

`endif

//--- bench/rv_core_tb.sv
module rv_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import rv_isa_pkg::*;

  localparam int    PERIOD       = 8;
  localparam int    STIM_DELAY   = 1;
  localparam int    RESET_CYCLES = 5;
  localparam int    IMEM_WORDS   = 64;
  localparam word_t RESET_PC     = 32'h0;
  localparam insn_t ECALL        = {25'd0, OP_ENVIRON};

  logic      clk;
  logic      rst;
  insn_t     i_insn;
  word_t     o_pc;
  logic      o_halt;
  logic      o_wb_en;
  reg_addr_t o_wb_rd;
  word_t     o_wb_data;

  // expected trace, one entry per executed instruction
  string     name_q[$];
  insn_t     insn_q[$];
  word_t     pc_q[$];
  logic      wb_en_q[$];
  reg_addr_t rd_q[$];
  word_t     data_q[$];
  logic      halt_q[$];

  insn_t imem [0:IMEM_WORDS-1];
  logic  fetch_en;
  int    error_count;
  int    check_count;

  rv_core #(
    .RESET_PC (RESET_PC),
    .NUM_REGS (32)
  ) rv_core_inst (
    .clk       (clk),
    .rst       (rst),
    .i_insn    (i_insn),
    .o_pc      (o_pc),
    .o_halt    (o_halt),
    .o_wb_en   (o_wb_en),
    .o_wb_rd   (o_wb_rd),
    .o_wb_data (o_wb_data)
  );

  always #(PERIOD / 2) clk = ~clk;

  // instruction memory, read at the pc just after each edge
  always @(posedge clk)
  begin
    #STIM_DELAY;
    if (fetch_en)
    begin
      i_insn = imem[o_pc >> 2];
    end
  end

  function automatic insn_t enc_i(logic [2:0] f3, reg_addr_t rd, reg_addr_t rs1,
                                  logic [11:0] imm);
    return {imm, rs1, f3, rd, OP_REG_IMM};
  endfunction

  function automatic insn_t enc_r(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd,
                                  reg_addr_t rs1, reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, OP_REG_REG};
  endfunction

  function automatic insn_t enc_u(opcode_t op, reg_addr_t rd, logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  // offset is in bytes, bit 0 is dropped by the format
  function automatic insn_t enc_b(logic [2:0] f3, reg_addr_t rs1, reg_addr_t rs2,
                                  logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
  endfunction

  task automatic add_row(input string name, input insn_t insn, input word_t pc,
                         input logic wb_en, input reg_addr_t rd, input word_t data,
                         input logic halt);
    name_q.push_back(name);
    insn_q.push_back(insn);
    pc_q.push_back(pc);
    wb_en_q.push_back(wb_en);
    rd_q.push_back(rd);
    data_q.push_back(data);
    halt_q.push_back(halt);
  endtask

  `include "rv_core_prog.svh"

  task automatic build_imem();
    // skipped words hold an unknown opcode tagged with their index
    for (int a = 0; a < IMEM_WORDS; a++)
    begin
      imem[a] = {a[24:0], 7'h7f};
    end
    foreach (pc_q[r])
    begin
      imem[pc_q[r] >> 2] = insn_q[r];
    end
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    check_count++;
    if (act !== exp)
    begin
      error_count++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_reg_addr(input string name, input reg_addr_t exp,
                                input reg_addr_t act);
    check_count++;
    if (act !== exp)
    begin
      error_count++;
      $display("CHECK FAILED %s: expected x%0d, actual x%0d", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    check_count++;
    if (act !== exp)
    begin
      error_count++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_row(input int r);
    string name;
    name = name_q[r];
    check_word({name, " pc"}, pc_q[r], o_pc);
    check_bit({name, " wb_en"}, wb_en_q[r], o_wb_en);
    if (wb_en_q[r])
    begin
      check_reg_addr({name, " rd"}, rd_q[r], o_wb_rd);
      check_word({name, " data"}, data_q[r], o_wb_data);
    end
    check_bit({name, " halt"}, halt_q[r], o_halt);
  endtask

  initial
  begin
    clk         = 1'b0;
    rst         = 1'b1;
    i_insn      = '0;
    fetch_en    = 1'b0;
    error_count = 0;
    check_count = 0;
    load_program();
    build_imem();
    // first edge loads the pc, later reset cycles are checked
    for (int c = 1; c < RESET_CYCLES; c++)
    begin
      @(posedge clk);
      #STIM_DELAY;
      // ecall and a register write take turns while reset masks both
      i_insn = c[0] ? ECALL : imem[0];
      #(PERIOD - STIM_DELAY - 1);
      check_word("reset pc", RESET_PC, o_pc);
      check_bit("reset wb_en", 1'b0, o_wb_en);
      check_bit("reset halt", 1'b0, o_halt);
    end
    // instruction memory drives the bus from the first cycle out of reset
    fetch_en = 1'b1;
    @(posedge clk);
    #STIM_DELAY;
    rst = 1'b0;
    for (int r = 0; r < name_q.size(); r++)
    begin
      // sample one ns before the edge that retires the row
      #(PERIOD - STIM_DELAY - 1);
      check_row(r);
      @(posedge clk);
      #STIM_DELAY;
    end
    $display("%0d errors in %0d checks", error_count, check_count);
    if (error_count == 0)
    begin
      $display("Everything OK");
    end
    else
    begin
      $display("Something failed");
    end
    $finish;
  end

  initial
  begin
    int limit;
    #1;
    limit = (name_q.size() + 10) * PERIOD;
    #(limit);
    $display("timeout: the program did not finish within %0d ns", limit);
    $display("Something failed");
    $finish;
  end

endmodule

//--- build.f
+incdir+bench
source/rv_isa_pkg.sv
source/core_ctrl_pkg.sv
source/fetch_decode.sv
source/reg_file.sv
source/execute.sv
source/rv_core.sv
bench/rv_core_tb.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - files:
      - source/rv_isa_pkg.sv
      - source/core_ctrl_pkg.sv
      - source/fetch_decode.sv
      - source/reg_file.sv
      - source/execute.sv
      - source/rv_core.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/rv_core_tb.sv
